/* src/rv_pkg.sv */
package rv_pkg;

  // Machine widths
  localparam int XLEN       = 32;
  localparam int REG_IDX_W  = 5;
  localparam int WORD_BYTES = 4;

  // funct7 patterns for the base integer set
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // Only word-sized loads and stores are supported
  localparam logic [2:0] F3_WORD = 3'b010;

  // Major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OPC_LOAD     = 7'b0000011,
    OPC_MISC_MEM = 7'b0001111,
    OPC_OP_IMM   = 7'b0010011,
    OPC_AUIPC    = 7'b0010111,
    OPC_STORE    = 7'b0100011,
    OPC_OP       = 7'b0110011,
    OPC_LUI      = 7'b0110111,
    OPC_BRANCH   = 7'b1100011,
    OPC_JALR     = 7'b1100111,
    OPC_JAL      = 7'b1101111,
    OPC_SYSTEM   = 7'b1110011
  } opcode_e;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  // Branch conditions, encoded as funct3
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } branch_e;

  // Register writeback source
  typedef enum logic [1:0] {
    WB_ALU      = 2'd0,
    WB_LOAD     = 2'd1,
    WB_PC_PLUS4 = 2'd2,
    WB_IMM      = 2'd3
  } wb_sel_e;

endpackage

/* src/reg_file.sv */
`timescale 1ns/1ps

module reg_file
  import rv_pkg::*;
#(
  parameter int NUM_REGS = 32
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [REG_IDX_W-1:0] i_rs1,
  input  logic [REG_IDX_W-1:0] i_rs2,
  input  logic [REG_IDX_W-1:0] i_rd,
  input  logic [XLEN-1:0]      i_rd_data,
  input  logic                 i_we,
  output logic [XLEN-1:0]      o_rs1_data,
  output logic [XLEN-1:0]      o_rs2_data
);

  localparam int IDX_W = $clog2(NUM_REGS);

  logic [XLEN-1:0] regs [NUM_REGS];

  // Indices above the implemented set read as zero (RV32E)
  assign o_rs1_data = (int'(i_rs1) < NUM_REGS) ? regs[i_rs1[IDX_W-1:0]] : '0;
  assign o_rs2_data = (int'(i_rs2) < NUM_REGS) ? regs[i_rs2[IDX_W-1:0]] : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_rd != '0 && int'(i_rd) < NUM_REGS) begin
      regs[i_rd[IDX_W-1:0]] <= i_rd_data;
    end
  end

  // x0 never picks up a value from any earlier write
  a_x0_rs1: assert property (@(posedge clk) disable iff (rst)
    (i_rs1 == '0) |-> (o_rs1_data == '0));
  a_x0_rs2: assert property (@(posedge clk) disable iff (rst)
    (i_rs2 == '0) |-> (o_rs2_data == '0));

endmodule

/* src/insn_decoder.sv */
`timescale 1ns/1ps

module insn_decoder
  import rv_pkg::*;
(
  input  logic [XLEN-1:0]      i_insn,
  output logic [REG_IDX_W-1:0] o_rs1,
  output logic [REG_IDX_W-1:0] o_rs2,
  output logic [REG_IDX_W-1:0] o_rd,
  output logic [XLEN-1:0]      o_imm,
  output alu_op_e              o_alu_op,
  output logic                 o_alu_src_imm,
  output logic                 o_alu_src_pc,
  output wb_sel_e              o_wb_sel,
  output logic                 o_reg_we,
  output logic                 o_load,
  output logic                 o_store,
  output logic                 o_branch,
  output logic                 o_jal,
  output logic                 o_jalr,
  output logic                 o_halt,
  output logic                 o_illegal
);

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic            is_reg;
  logic            is_ecall;
  alu_op_e         arith_op;
  logic            arith_bad;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;

  assign opcode = opcode_e'(i_insn[6:0]);
  assign funct3 = i_insn[14:12];
  assign funct7 = i_insn[31:25];
  assign o_rd   = i_insn[11:7];
  assign o_rs1  = i_insn[19:15];
  assign o_rs2  = i_insn[24:20];

  // Sign-extended immediates for each format
  assign imm_i = {{(XLEN-12){i_insn[31]}}, i_insn[31:20]};
  assign imm_s = {{(XLEN-12){i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
  assign imm_b = {{(XLEN-13){i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25],
                  i_insn[11:8], 1'b0};
  assign imm_u = {i_insn[31:12], 12'b0};
  assign imm_j = {{(XLEN-21){i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20],
                  i_insn[30:21], 1'b0};

  assign is_reg   = (opcode == OPC_OP);
  assign is_ecall = (opcode == OPC_SYSTEM) && (i_insn[31:7] == '0);

  // Shared funct3/funct7 mapping for OP and OP-IMM
  always_comb begin
    arith_op  = ALU_ADD;
    arith_bad = 1'b0;
    case (funct3)
      3'b000: begin
        arith_op  = (is_reg && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
        arith_bad = is_reg && funct7 != F7_BASE && funct7 != F7_ALT;
      end
      3'b001: begin
        arith_op  = ALU_SLL;
        arith_bad = funct7 != F7_BASE;
      end
      3'b010: begin
        arith_op  = ALU_SLT;
        arith_bad = is_reg && funct7 != F7_BASE;
      end
      3'b011: begin
        arith_op  = ALU_SLTU;
        arith_bad = is_reg && funct7 != F7_BASE;
      end
      3'b100: begin
        arith_op  = ALU_XOR;
        arith_bad = is_reg && funct7 != F7_BASE;
      end
      3'b101: begin
        arith_op  = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
        arith_bad = funct7 != F7_BASE && funct7 != F7_ALT;
      end
      3'b110: begin
        arith_op  = ALU_OR;
        arith_bad = is_reg && funct7 != F7_BASE;
      end
      3'b111: begin
        arith_op  = ALU_AND;
        arith_bad = is_reg && funct7 != F7_BASE;
      end
    endcase
  end

  always_comb begin
    o_imm         = imm_i;
    o_alu_op      = ALU_ADD;
    o_alu_src_imm = 1'b0;
    o_alu_src_pc  = 1'b0;
    o_wb_sel      = WB_ALU;
    o_reg_we      = 1'b0;
    o_load        = 1'b0;
    o_store       = 1'b0;
    o_branch      = 1'b0;
    o_jal         = 1'b0;
    o_jalr        = 1'b0;
    o_illegal     = 1'b0;
    case (opcode)
      OPC_LUI: begin
        o_imm    = imm_u;
        o_wb_sel = WB_IMM;
        o_reg_we = 1'b1;
      end
      OPC_AUIPC: begin
        o_imm         = imm_u;
        o_alu_src_pc  = 1'b1;
        o_alu_src_imm = 1'b1;
        o_reg_we      = 1'b1;
      end
      OPC_JAL: begin
        o_imm    = imm_j;
        o_jal    = 1'b1;
        o_wb_sel = WB_PC_PLUS4;
        o_reg_we = 1'b1;
      end
      OPC_JALR: begin
        o_alu_src_imm = 1'b1;
        o_jalr        = 1'b1;
        o_wb_sel      = WB_PC_PLUS4;
        o_reg_we      = 1'b1;
      end
      OPC_BRANCH: begin
        // Condition comes from the ALU compare, target from the PC adder
        o_imm     = imm_b;
        o_alu_op  = ALU_SUB;
        o_branch  = 1'b1;
        o_illegal = (funct3 == 3'b010) || (funct3 == 3'b011);
      end
      OPC_LOAD: begin
        o_alu_src_imm = 1'b1;
        o_load        = 1'b1;
        o_wb_sel      = WB_LOAD;
        o_reg_we      = 1'b1;
        o_illegal     = funct3 != F3_WORD;
      end
      OPC_STORE: begin
        o_imm         = imm_s;
        o_alu_src_imm = 1'b1;
        o_store       = 1'b1;
        o_illegal     = funct3 != F3_WORD;
      end
      OPC_OP_IMM: begin
        o_alu_op      = arith_op;
        o_alu_src_imm = 1'b1;
        o_reg_we      = 1'b1;
        o_illegal     = arith_bad;
      end
      OPC_OP: begin
        o_alu_op  = arith_op;
        o_reg_we  = 1'b1;
        o_illegal = arith_bad;
      end
      // FENCE does nothing on a single in-order core
      OPC_MISC_MEM: begin
      end
      OPC_SYSTEM: o_illegal = !is_ecall;
      default:    o_illegal = 1'b1;
    endcase

    // A halting instruction has no side effects
    o_halt = is_ecall || o_illegal;
    if (o_halt) begin
      o_reg_we = 1'b0;
      o_load   = 1'b0;
      o_store  = 1'b0;
      o_branch = 1'b0;
      o_jal    = 1'b0;
      o_jalr   = 1'b0;
    end
  end

endmodule

/* src/alu.sv */
`timescale 1ns/1ps

module alu
  import rv_pkg::*;
(
  input  alu_op_e         i_op,
  input  logic [XLEN-1:0] i_a,
  input  logic [XLEN-1:0] i_b,
  input  branch_e         i_branch_cond,
  output logic [XLEN-1:0] o_result,
  output logic            o_taken
);

  localparam int SHAMT_W = $clog2(XLEN);

  logic [SHAMT_W-1:0] shamt;
  logic [XLEN-1:0]    diff;
  logic               eq;
  logic               lt_s;
  logic               lt_u;

  assign shamt = i_b[SHAMT_W-1:0];
  assign diff  = i_a - i_b;

  // Compare results, shared by SLT/SLTU and the branches
  assign eq   = (diff == '0);
  assign lt_s = $signed(i_a) < $signed(i_b);
  assign lt_u = i_a < i_b;

  always_comb begin
    case (i_op)
      ALU_ADD:  o_result = i_a + i_b;
      ALU_SUB:  o_result = diff;
      ALU_SLL:  o_result = i_a << shamt;
      ALU_SLT:  o_result = XLEN'(lt_s);
      ALU_SLTU: o_result = XLEN'(lt_u);
      ALU_XOR:  o_result = i_a ^ i_b;
      ALU_SRL:  o_result = i_a >> shamt;
      ALU_SRA:  o_result = $unsigned($signed(i_a) >>> shamt);
      ALU_OR:   o_result = i_a | i_b;
      ALU_AND:  o_result = i_a & i_b;
      default:  o_result = '0;
    endcase
  end

  always_comb begin
    case (i_branch_cond)
      BR_BEQ:  o_taken = eq;
      BR_BNE:  o_taken = !eq;
      BR_BLT:  o_taken = lt_s;
      BR_BGE:  o_taken = !lt_s;
      BR_BLTU: o_taken = lt_u;
      BR_BGEU: o_taken = !lt_u;
      // funct3 010 and 011 are rejected by the decoder
      default: o_taken = 1'b0;
    endcase
  end

endmodule

/* src/rv_core.sv */
`timescale 1ns/1ps

module rv_core
  import rv_pkg::*;
#(
  parameter logic [XLEN-1:0] RESET_PC = '0,
  parameter int              NUM_REGS = 32
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [XLEN-1:0]       i_insn,
  input  logic [XLEN-1:0]       i_dmem_rdata,
  output logic [XLEN-1:0]       o_pc,
  output logic [XLEN-1:0]       o_dmem_addr,
  output logic [XLEN-1:0]       o_dmem_wdata,
  output logic [WORD_BYTES-1:0] o_dmem_we,
  output logic                  o_halt,
  output logic                  o_illegal
);

  localparam int ADDR_LSB = $clog2(WORD_BYTES);

  logic [REG_IDX_W-1:0] rs1;
  logic [REG_IDX_W-1:0] rs2;
  logic [REG_IDX_W-1:0] rd;
  logic [XLEN-1:0]      imm;
  alu_op_e              alu_op;
  logic                 alu_src_imm;
  logic                 alu_src_pc;
  wb_sel_e              wb_sel;
  logic                 reg_we;
  logic                 is_load;
  logic                 is_store;
  logic                 is_branch;
  logic                 is_jal;
  logic                 is_jalr;

  logic [XLEN-1:0]      rs1_data;
  logic [XLEN-1:0]      rs2_data;
  logic [XLEN-1:0]      alu_a;
  logic [XLEN-1:0]      alu_b;
  logic [XLEN-1:0]      alu_result;
  logic                 taken;

  logic [XLEN-1:0]      pc_q;
  logic [XLEN-1:0]      pc_next;
  logic [XLEN-1:0]      pc_plus4;
  logic [XLEN-1:0]      pc_target;
  logic [XLEN-1:0]      jalr_target;
  logic [ADDR_LSB-1:0]  mem_offset;
  logic                 mem_misaligned;
  logic [XLEN-1:0]      rd_data;
  logic                 rd_we;

  insn_decoder u_decoder (
    .i_insn       (i_insn),
    .o_rs1        (rs1),
    .o_rs2        (rs2),
    .o_rd         (rd),
    .o_imm        (imm),
    .o_alu_op     (alu_op),
    .o_alu_src_imm(alu_src_imm),
    .o_alu_src_pc (alu_src_pc),
    .o_wb_sel     (wb_sel),
    .o_reg_we     (reg_we),
    .o_load       (is_load),
    .o_store      (is_store),
    .o_branch     (is_branch),
    .o_jal        (is_jal),
    .o_jalr       (is_jalr),
    .o_halt       (o_halt),
    .o_illegal    (o_illegal)
  );

  reg_file #(
    .NUM_REGS(NUM_REGS)
  ) u_reg_file (
    .clk       (clk),
    .rst       (rst),
    .i_rs1     (rs1),
    .i_rs2     (rs2),
    .i_rd      (rd),
    .i_rd_data (rd_data),
    .i_we      (rd_we),
    .o_rs1_data(rs1_data),
    .o_rs2_data(rs2_data)
  );

  // AUIPC feeds the PC into the A side
  assign alu_a = alu_src_pc ? pc_q : rs1_data;
  assign alu_b = alu_src_imm ? imm : rs2_data;

  alu u_alu (
    .i_op         (alu_op),
    .i_a          (alu_a),
    .i_b          (alu_b),
    .i_branch_cond(branch_e'(i_insn[14:12])),
    .o_result     (alu_result),
    .o_taken      (taken)
  );

  // Program counter
  assign pc_plus4    = pc_q + XLEN'(WORD_BYTES);
  assign pc_target   = pc_q + imm;
  assign jalr_target = {alu_result[XLEN-1:1], 1'b0};

  always_comb begin
    if (o_halt) begin
      pc_next = pc_q;
    end else if (is_jal) begin
      pc_next = pc_target;
    end else if (is_jalr) begin
      pc_next = jalr_target;
    end else if (is_branch && taken) begin
      pc_next = pc_target;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign o_pc = pc_q;

  // Data memory uses word accesses only
  assign mem_offset     = alu_result[ADDR_LSB-1:0];
  assign mem_misaligned = (mem_offset != '0);
  assign o_dmem_addr    = {alu_result[XLEN-1:ADDR_LSB], {ADDR_LSB{1'b0}}};
  assign o_dmem_wdata   = rs2_data;
  assign o_dmem_we      = (is_store && !mem_misaligned) ? '1 : '0;

  // Writeback
  assign rd_we = reg_we && !(is_load && mem_misaligned);

  always_comb begin
    case (wb_sel)
      WB_ALU:      rd_data = alu_result;
      WB_LOAD:     rd_data = i_dmem_rdata;
      WB_PC_PLUS4: rd_data = pc_plus4;
      WB_IMM:      rd_data = imm;
      default:     rd_data = alu_result;
    endcase
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
    pc_q[ADDR_LSB-1:0] == '0);

  // Byte enables only go out for an aligned effective address
  a_store_aligned: assert property (@(posedge clk) disable iff (rst)
    (o_dmem_we != '0) |-> (o_dmem_addr == rs1_data + imm));

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 4
) (
  input  logic i_restart,
  output logic clk,
  output logic rst
);

  logic clk_q = 1'b0;
  logic rst_q = 1'b1;
  int   cycles = 0;

  assign clk = clk_q;
  assign rst = rst_q;

  always #(PERIOD_NS / 2) clk_q = ~clk_q;

  // Reset held while restart is high, then for RESET_CYCLES more edges
  always @(posedge clk_q) begin
    #1;
    if (i_restart) begin
      cycles = 0;
    end else if (cycles < RESET_CYCLES) begin
      cycles = cycles + 1;
    end
    rst_q = (cycles < RESET_CYCLES);
  end

endmodule

/* bench/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb;

  localparam logic [6:0] OP_LOAD  = 7'b0000011;
  localparam logic [6:0] OP_IMM   = 7'b0010011;
  localparam logic [6:0] OP_AUIPC = 7'b0010111;
  localparam logic [6:0] OP_LUI   = 7'b0110111;
  localparam logic [6:0] OP_JALR  = 7'b1100111;
  localparam logic [31:0] ECALL   = 32'h0000_0073;

  logic        clk;
  logic        rst;
  logic        restart = 1'b0;
  logic [31:0] pc;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic [3:0]  dmem_we;
  logic        halt;
  logic        illegal;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] ref_mem [256];
  logic [31:0] prog [$];
  logic [31:0] lcg_state;
  int          tests_run = 0;
  int          tests_failed = 0;

  tb_clock #(.PERIOD_NS(100), .RESET_CYCLES(4)) clock_i (
    .i_restart(restart),
    .clk      (clk),
    .rst      (rst)
  );

  rv_core #(.RESET_PC(32'h0), .NUM_REGS(32)) dut_i (
    .clk         (clk),
    .rst         (rst),
    .i_insn      (imem[pc[9:2]]),
    .i_dmem_rdata(dmem[dmem_addr[9:2]]),
    .o_pc        (pc),
    .o_dmem_addr (dmem_addr),
    .o_dmem_wdata(dmem_wdata),
    .o_dmem_we   (dmem_we),
    .o_halt      (halt),
    .o_illegal   (illegal)
  );

  // Byte-enabled data memory write
  always @(posedge clk) begin
    if (!rst) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_we[b]) dmem[dmem_addr[9:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
      end
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  function automatic logic [31:0] fill_word(input int i);
    return 32'h5A3C_0000 ^ (32'(i) * 32'h9E37_79B1);
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // Integer result by funct3 as the ISA defines it
  function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'b0, $signed(a) < $signed(b)};
      3'd3: return {31'b0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // Instruction-set interpreter over imem and ref_mem that returns the halting PC
  function automatic logic [31:0] rv_ref_run(output logic bad);
    logic [31:0] regs [32];
    logic [31:0] insn;
    logic [31:0] cur;
    logic [31:0] nxt;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] val;
    logic [31:0] addr;
    logic [31:0] immi;
    logic [31:0] imms;
    logic [31:0] immb;
    logic [31:0] immj;
    logic [2:0]  f3;
    logic        wr;
    logic        cond;
    cur = 32'h0;
    bad = 1'b0;
    for (int i = 0; i < 32; i++) regs[i] = 32'h0;
    for (int step = 0; step < 4000; step++) begin
      insn = imem[cur[9:2]];
      f3   = insn[14:12];
      a    = regs[insn[19:15]];
      b    = regs[insn[24:20]];
      immi = {{20{insn[31]}}, insn[31:20]};
      imms = {{20{insn[31]}}, insn[31:25], insn[11:7]};
      immb = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
      immj = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
      nxt  = cur + 32'd4;
      wr   = 1'b0;
      val  = 32'h0;
      cond = 1'b0;
      case (insn[6:0])
        7'b0110111: begin
          wr  = 1'b1;
          val = {insn[31:12], 12'b0};
        end
        7'b0010111: begin
          wr  = 1'b1;
          val = cur + {insn[31:12], 12'b0};
        end
        7'b1101111: begin
          wr  = 1'b1;
          val = cur + 32'd4;
          nxt = cur + immj;
        end
        7'b1100111: begin
          wr  = 1'b1;
          val = cur + 32'd4;
          nxt = (a + immi) & ~32'h1;
        end
        7'b1100011: begin
          case (f3)
            3'd0: cond = (a == b);
            3'd1: cond = (a != b);
            3'd4: cond = $signed(a) < $signed(b);
            3'd5: cond = $signed(a) >= $signed(b);
            3'd6: cond = a < b;
            3'd7: cond = a >= b;
            default: bad = 1'b1;
          endcase
          if (cond) nxt = cur + immb;
        end
        7'b0000011: begin
          addr = a + immi;
          wr   = (f3 == 3'b010) && (addr[1:0] == 2'b00);
          val  = ref_mem[addr[9:2]];
          if (f3 != 3'b010) bad = 1'b1;
        end
        7'b0100011: begin
          addr = a + imms;
          if (f3 != 3'b010) bad = 1'b1;
          else if (addr[1:0] == 2'b00) ref_mem[addr[9:2]] = b;
        end
        7'b0010011: begin
          wr  = 1'b1;
          val = arith(f3, f3 == 3'd5 && insn[30], a, immi);
        end
        7'b0110011: begin
          wr  = 1'b1;
          val = arith(f3, insn[30], a, b);
          if (insn[31:25] != 7'h00 && !(insn[31:25] == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))
            bad = 1'b1;
        end
        7'b0001111: wr = 1'b0;
        7'b1110011: begin
          if (insn[31:7] != 25'h0) bad = 1'b1;
          return cur;
        end
        default: bad = 1'b1;
      endcase
      if (bad) return cur;
      if (wr && insn[11:7] != 5'd0) regs[insn[11:7]] = val;
      cur = nxt;
    end
    return cur;
  endfunction

  task automatic emit(input logic [31:0] insn);
    prog.push_back(insn);
  endtask

  task automatic run_test(input string name);
    logic [31:0] exp_pc;
    logic        exp_bad;
    int          errors;
    int          cnt;
    errors = 0;
    cnt = 0;
    #1 restart = 1'b1;
    while (!rst && cnt < 20) begin
      @(posedge clk);
      #2;
      cnt++;
    end
    if (!rst) begin
      $display("%s: reset never asserted", name);
      errors++;
    end
    for (int i = 0; i < 256; i++) begin
      imem[i]    = (i < prog.size()) ? prog[i] : 32'h0;
      dmem[i]    <= fill_word(i);
      ref_mem[i] = fill_word(i);
    end
    exp_pc = rv_ref_run(exp_bad);
    restart = 1'b0;
    cnt = 0;
    while (rst && cnt < 20) begin
      @(posedge clk);
      #2;
      cnt++;
    end
    if (rst) begin
      $display("%s: reset never released", name);
      errors++;
    end
    cnt = 0;
    while (!halt && cnt < 2000) begin
      @(posedge clk);
      #2;
      cnt++;
    end
    if (!halt) begin
      $display("%s: program never halted within 2000 cycles", name);
      errors++;
    end else begin
      // A halted core must neither move nor write on the next edge
      @(posedge clk);
      #2;
    end
    for (int i = 0; i < 256; i++) begin
      if (dmem[i] !== ref_mem[i]) begin
        $display("Fail %s dmem[%0d] expected %h actual %h", name, i, ref_mem[i], dmem[i]);
        errors++;
      end
    end
    if (pc !== exp_pc) begin
      $display("Fail %s pc expected %h actual %h", name, exp_pc, pc);
      errors++;
    end
    if (illegal !== exp_bad) begin
      $display("Fail %s illegal expected %b actual %b", name, exp_bad, illegal);
      errors++;
    end
    tests_run++;
    if (errors != 0) tests_failed++;
    $display("%s: %s (%0d mismatches)", name, errors == 0 ? "passed" : "failed", errors);
    prog.delete();
  endtask

  task automatic build_random();
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic        alt;
    for (int k = 1; k <= 8; k++) begin
      r = lcg_next();
      emit(enc_u(r[31:12], 5'(k), OP_LUI));
      emit(enc_i(r[11:0], 5'(k), 3'd0, 5'(k), OP_IMM));
    end
    repeat (30) begin
      r   = lcg_next();
      alt = r[3];
      rd  = {2'b0, r[6:4]} + 5'd1;
      rs1 = {2'b0, r[9:7]} + 5'd1;
      rs2 = {2'b0, r[12:10]} + 5'd1;
      if (r[13]) begin
        emit(enc_r((alt && (r[2:0] == 3'd0 || r[2:0] == 3'd5)) ? 7'h20 : 7'h00,
                   rs2, rs1, r[2:0], rd));
      end else begin
        if (r[2:0] == 3'd1) imm = {7'h0, r[24:20]};
        else if (r[2:0] == 3'd5) imm = {1'b0, alt, 5'b0, r[24:20]};
        else imm = r[31:20];
        emit(enc_i(imm, rs1, r[2:0], rd, OP_IMM));
      end
    end
    for (int k = 1; k <= 8; k++) emit(enc_s(12'(4 * (k - 1)), 5'(k), 5'd0));
    emit(ECALL);
  endtask

  initial begin
    lcg_state = 32'd37;
    for (int i = 0; i < 256; i++) begin
      imem[i] = 32'h0;
      dmem[i] <= fill_word(i);
    end

    // ALU ops on -7 and 3 with results stored from x3 upward
    emit(enc_i(12'hFF9, 5'd0, 3'd0, 5'd1, OP_IMM));
    emit(enc_i(12'h003, 5'd0, 3'd0, 5'd2, OP_IMM));
    for (int k = 0; k < 8; k++) emit(enc_r(7'h00, 5'd2, 5'd1, 3'(k), 5'(3 + k)));
    emit(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd11));
    emit(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd12));
    emit(enc_i(12'h004, 5'd1, 3'd1, 5'd13, OP_IMM));
    emit(enc_i(12'h402, 5'd1, 3'd5, 5'd14, OP_IMM));
    emit(enc_i(12'hFFF, 5'd1, 3'd3, 5'd15, OP_IMM));
    emit(enc_i(12'h005, 5'd1, 3'd2, 5'd16, OP_IMM));
    for (int k = 3; k <= 16; k++) emit(enc_s(12'(4 * (k - 3)), 5'(k), 5'd0));
    emit(ECALL);
    run_test("alu ops");

    emit(enc_u(20'h12345, 5'd1, OP_LUI));
    emit(enc_u(20'h00010, 5'd2, OP_AUIPC));
    emit(enc_i(12'h037, 5'd0, 3'd0, 5'd0, OP_IMM));
    emit(enc_i(12'h005, 5'd0, 3'd0, 5'd3, OP_IMM));
    for (int k = 0; k < 4; k++) emit(enc_s(12'(4 * k), 5'(k), 5'd0));
    emit(ECALL);
    run_test("upper imm and x0");

    // Countdown loop per branch condition with the trip count stored
    emit(enc_i(12'h001, 5'd0, 3'd0, 5'd2, OP_IMM));
    for (int c = 0; c < 6; c++) begin
      emit(enc_i(12'(3 + c), 5'd0, 3'd0, 5'd1, OP_IMM));
      emit(enc_i(12'h000, 5'd0, 3'd0, 5'd5, OP_IMM));
      emit(enc_i(12'h001, 5'd5, 3'd0, 5'd5, OP_IMM));
      emit(enc_i(12'hFFF, 5'd1, 3'd0, 5'd1, OP_IMM));
      case (c)
        0: emit(enc_b(13'h1FF8, 5'd0, 5'd1, 3'd1));
        1: emit(enc_b(13'h1FF8, 5'd1, 5'd0, 3'd4));
        2: emit(enc_b(13'h1FF8, 5'd2, 5'd1, 3'd5));
        3: emit(enc_b(13'h1FF8, 5'd1, 5'd0, 3'd6));
        4: emit(enc_b(13'h1FF8, 5'd2, 5'd1, 3'd7));
        default: begin
          emit(enc_b(13'h0008, 5'd0, 5'd1, 3'd0));
          emit(enc_j(21'h1FFFF4, 5'd0));
        end
      endcase
      emit(enc_s(12'(4 * c), 5'd5, 5'd0));
    end
    emit(ECALL);
    run_test("branches");

    emit(enc_j(21'h000008, 5'd1));
    emit(enc_i(12'd99, 5'd0, 3'd0, 5'd9, OP_IMM));
    emit(enc_s(12'h000, 5'd1, 5'd0));
    emit(enc_u(20'h00000, 5'd2, OP_AUIPC));
    emit(enc_i(12'd17, 5'd2, 3'd0, 5'd2, OP_IMM));
    emit(enc_i(12'h000, 5'd2, 3'd0, 5'd3, OP_JALR));
    emit(enc_i(12'd77, 5'd0, 3'd0, 5'd9, OP_IMM));
    emit(enc_s(12'h004, 5'd3, 5'd0));
    emit(enc_s(12'h008, 5'd9, 5'd0));
    emit(ECALL);
    run_test("jal and jalr");

    emit(enc_i(12'h123, 5'd0, 3'd0, 5'd1, OP_IMM));
    emit(enc_s(12'd16, 5'd1, 5'd0));
    emit(enc_i(12'd16, 5'd0, 3'b010, 5'd2, OP_LOAD));
    emit(enc_s(12'd20, 5'd2, 5'd0));
    emit(enc_s(12'd25, 5'd1, 5'd0));
    emit(enc_i(12'h007, 5'd0, 3'd0, 5'd3, OP_IMM));
    emit(enc_i(12'd29, 5'd0, 3'b010, 5'd3, OP_LOAD));
    emit(enc_s(12'd32, 5'd3, 5'd0));
    emit(enc_i(12'd40, 5'd0, 3'b010, 5'd4, OP_LOAD));
    emit(enc_s(12'd44, 5'd4, 5'd0));
    emit(ECALL);
    run_test("load store");

    for (int n = 0; n < 20; n++) begin
      build_random();
      run_test($sformatf("random %0d", n));
    end

    emit(enc_i(12'h003, 5'd0, 3'd0, 5'd1, OP_IMM));
    emit(enc_s(12'h000, 5'd1, 5'd0));
    emit(32'h0000_007F);
    emit(enc_s(12'h004, 5'd1, 5'd0));
    run_test("illegal opcode");

    $display("%0d tests run, %0d failed", tests_run, tests_failed);
    if (tests_failed == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* rv_core.f */
src/rv_pkg.sv
src/reg_file.sv
src/insn_decoder.sv
src/alu.sv
src/rv_core.sv
bench/tb_clock.sv
bench/rv_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module rv_core_tb -f rv_core.f -o rv_core_sim

output=$(./obj_dir/rv_core_sim)
echo "$output"

if grep -qx "Test OK" <<< "$output"; then
  exit 0
else
  exit 1
fi
